/* common/nes_bus_pkg.sv */
//----------------------------------------
// NES CPU bus definitions
//----------------------------------------
package nes_bus_pkg;

	// Basic bus words
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;

	// Master clock division
	localparam logic [4:0] cpu_div            = 5'd12; // Master clocks per CPU cycle
	localparam logic [2:0] ppu_div            = 3'd4;  // Master clocks per PPU tick
	localparam logic [2:0] pal_stretch_period = 3'd5;  // PAL adds a PPU tick every 5th cycle

	// Register addresses
	localparam addr_t oam_dma_reg    = 16'h4014; // Sprite DMA page write
	localparam addr_t oam_data_reg   = 16'h2004; // OAM data port in the PPU
	localparam addr_t apu_status_reg = 16'h4015;
	localparam addr_t joy1_reg       = 16'h4016; // Strobe on write, pad 1 on read
	localparam addr_t joy2_reg       = 16'h4017;

	// Decode range bounds, lower inclusive and upper exclusive
	localparam addr_t ppu_base   = 16'h2000;
	localparam addr_t apu_base   = 16'h4000; // Also the end of the PPU range
	localparam addr_t apu_limit  = 16'h4018;
	localparam addr_t open_limit = 16'h4100; // 4018h..40FFh floats

	// Request from the CPU core, 25 bits
	typedef struct packed {
		addr_t addr;
		logic  rnw;   // 1 = read
		byte_t wdata;
	} cpu_req_t;

	// Cycle driven onto the outgoing bus, 26 bits
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic  read;
		logic  write;
	} bus_cycle_t;

	// Sample fetch request from the APU DMC channel, 17 bits
	typedef struct packed {
		logic  trigger;
		addr_t addr;   // Sample byte address
	} dmc_req_t;

	// Decoded chip selects
	typedef struct packed {
		logic apu;    // 4000h..4017h
		logic ppu;    // 2000h..3FFFh
		logic joy1;
		logic joy2;
		logic status;
		logic open;   // Unmapped range, reads float
	} chip_sel_t;

endpackage

/* rtl/nes_clock_gen.sv */
//----------------------------------------
// Master clock dividers
//----------------------------------------
module nes_clock_gen import nes_bus_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic pal,       // Sampled while reset is high
	output logic cpu_ce,
	output logic ppu_ce,
	output logic ppu_io,    // Tick on which a PPU register access lands
	output logic odd_cycle
);

	// Timing of one NTSC CPU cycle of 12 master clocks
	//   clk  1 2 3 4 5 6 7 8 9 A B C
	//   ppu        P       P       P
	//   cpu                        C
	// A stretched PAL cycle holds the CPU divider through the first tick

	logic       pal_mode;  // Video standard for this run
	logic [4:0] div_cpu;   // 1..cpu_div
	logic [2:0] div_ppu;   // 1..ppu_div
	logic [1:0] ppu_tick;  // PPU tick index within the CPU cycle
	logic [2:0] pal_cnt;   // CPU cycle index within the PAL group of five
	logic       stretch;   // Current cycle is the long one
	logic       hold_cpu;

	assign cpu_ce   = (div_cpu == cpu_div);
	assign ppu_ce   = (div_ppu == ppu_div);
	assign stretch  = (pal_cnt == pal_stretch_period - 3'd1);
	assign hold_cpu = stretch && (ppu_tick == 2'd0); // Extra tick goes in first

	// Register access moves one tick later when the cycle is stretched
	assign ppu_io = (ppu_tick == (stretch ? 2'd2 : 2'd1));

	always_ff @(posedge clk) begin
		if (reset) begin
			pal_mode  <= pal;
			div_cpu   <= 5'd1;
			div_ppu   <= 3'd1;
			ppu_tick  <= 2'd0;
			pal_cnt   <= 3'd0;
			odd_cycle <= 1'b0;
		end else begin
			div_ppu <= ppu_ce ? 3'd1 : div_ppu + 3'd1; // Free running, never paused

			if (cpu_ce)
				div_cpu <= 5'd1;
			else if (!hold_cpu)
				div_cpu <= div_cpu + 5'd1;

			// Tick index restarts with every CPU cycle
			if (cpu_ce)
				ppu_tick <= 2'd0;
			else if (ppu_ce)
				ppu_tick <= ppu_tick + 2'd1;

			if (cpu_ce) begin
				odd_cycle <= ~odd_cycle;
				if (pal_mode)
					pal_cnt <= stretch ? 3'd0 : pal_cnt + 3'd1; // NTSC stays at 0
			end
		end
	end

	// CPU strobe lands on a PPU tick and comes back within a stretched cycle
	a_ce_gap: assert property (@(posedge clk) disable iff (reset)
		cpu_ce |-> ppu_ce ##[1:16] cpu_ce);

endmodule

/* dma/oam_dmc_dma.sv */
//----------------------------------------
// Sprite and DMC DMA
//----------------------------------------
module oam_dmc_dma import nes_bus_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       cpu_ce,
	input  logic       odd_cycle,
	input  logic       sprite_trigger, // Bus write to 4014h
	input  cpu_req_t   cpu_req,
	input  dmc_req_t   dmc,
	input  byte_t      rdata,          // Byte returned for the current cycle
	output bus_cycle_t dma_cycle,
	output logic       dma_active,     // DMA owns the bus this cycle
	output logic       pause_cpu,
	output logic       dmc_ack
);

	// Sprite DMA reads on even cycles and writes 2004h on odd ones
	// A DMC fetch takes an even cycle; the sprite copy then waits one odd
	// cycle and repeats the same source address

	logic       dmc_state;  // DMC fetch pending
	logic [1:0] spr_state;  // 00 idle, 01 waiting to start, 11 copying
	addr_t      spr_addr;   // Page in the high byte, index in the low byte
	byte_t      last_val;   // Byte from the last sprite read
	logic [8:0] next_lo;    // Index plus one with the end of page in bit 8
	logic       spr_run;
	logic       spr_read;   // Sprite read that is not displaced by DMC

	assign spr_run  = spr_state[1];
	assign next_lo  = {1'b0, spr_addr[7:0]} + 9'd1;
	assign spr_read = spr_run && !odd_cycle && !dmc_ack;

	// Control state moves only at CPU cycle boundaries
	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= 1'b0;
			spr_state <= 2'b00;
		end else if (cpu_ce) begin
			// DMC is accepted on an even cycle while the CPU reads
			if (!dmc_state && dmc.trigger && cpu_req.rnw && !odd_cycle)
				dmc_state <= 1'b1;
			else if (dmc_state && !odd_cycle)
				dmc_state <= 1'b0;          // Ack cycle done

			if (sprite_trigger)
				spr_state <= 2'b01;
			else if (spr_state == 2'b01 && cpu_req.rnw && odd_cycle)
				spr_state <= 2'b11;         // Halt point reached, copy from next even
			else if (spr_run && dmc_ack)
				spr_state <= 2'b01;         // DMC took the read slot
			else if (spr_run && odd_cycle && next_lo[8])
				spr_state <= 2'b00;         // 256th write
		end
	end

	// Source pointer and data latch
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger)
				spr_addr <= {cpu_req.wdata, 8'h00};
			else if (spr_run && odd_cycle)
				spr_addr[7:0] <= next_lo[7:0]; // Advance after each write
			if (spr_read)
				last_val <= rdata;
		end
	end

	assign dmc_ack    = dmc_state && !odd_cycle;
	assign dma_active = dmc_ack || spr_run;
	assign pause_cpu  = spr_state[0] || dmc.trigger; // Low bit set while requested or copying

	// Outgoing cycle that the decoder uses only while dma_active is high
	always_comb begin
		if (dmc_ack)
			dma_cycle.addr = dmc.addr;
		else if (odd_cycle)
			dma_cycle.addr = oam_data_reg;
		else
			dma_cycle.addr = spr_addr;
		dma_cycle.wdata = last_val;
		dma_cycle.read  = !odd_cycle;
		dma_cycle.write = odd_cycle;
	end

	// The ack clears the pending fetch and is followed by an odd cycle
	a_dmc_even: assert property (@(posedge clk) disable iff (reset)
		(dmc_ack && cpu_ce) |=> (odd_cycle && !dmc_state));

endmodule

/* rtl/bus_decode.sv */
//----------------------------------------
// Bus master select and decode
//----------------------------------------
module bus_decode import nes_bus_pkg::*; (
	input  cpu_req_t   cpu_req,
	input  bus_cycle_t dma_cycle,
	input  logic       dma_active,
	output bus_cycle_t bus,
	output chip_sel_t  sel,
	output logic       sprite_trigger,
	output logic       joypad_strobe,
	output logic [1:0] joypad_clock   // Bit 1 pad 2, bit 0 pad 1
);

	bus_cycle_t cpu_cycle;

	// CPU request recast as an outgoing cycle
	always_comb begin
		cpu_cycle.addr  = cpu_req.addr;
		cpu_cycle.wdata = cpu_req.wdata;
		cpu_cycle.read  = cpu_req.rnw;
		cpu_cycle.write = !cpu_req.rnw;
	end

	assign bus = dma_active ? dma_cycle : cpu_cycle; // DMA wins the bus

	// Range selects
	always_comb begin
		sel.ppu    = (bus.addr >= ppu_base) && (bus.addr < apu_base);
		sel.apu    = (bus.addr >= apu_base) && (bus.addr < apu_limit);
		sel.open   = (bus.addr >= apu_limit) && (bus.addr < open_limit);
		sel.joy1   = (bus.addr == joy1_reg);
		sel.joy2   = (bus.addr == joy2_reg);
		sel.status = (bus.addr == apu_status_reg);
	end

	// Page write starts the sprite copy
	assign sprite_trigger = bus.write && (bus.addr == oam_dma_reg);

	// Joypads live inside the APU range
	assign joypad_strobe = sel.joy1 && bus.write && bus.wdata[0];
	assign joypad_clock  = {sel.joy2 && bus.read, sel.joy1 && bus.read};

endmodule

/* rtl/read_data_mux.sv */
//----------------------------------------
// CPU read data and open bus
//----------------------------------------
module read_data_mux import nes_bus_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  chip_sel_t  sel,
	input  byte_t      ppu_rdata,
	input  byte_t      apu_status,
	input  byte_t      mem_rdata,
	input  logic [3:0] joypad_data, // Pads 0..1 and power pad bits 2..3
	input  logic       mic,
	output byte_t      data_in
);

	byte_t open_bus; // Last value seen on the data bus

	// Joypad ports drive only some bits; the rest float at the old bus value
	byte_t joy1_byte;
	byte_t joy2_byte;

	assign joy1_byte = {open_bus[7:5], 2'b00, mic, 1'b0, joypad_data[0]};
	assign joy2_byte = {open_bus[7:5], joypad_data[3:2], 2'b00, joypad_data[1]};

	always_comb begin
		if (reset)
			data_in = '0;
		else if (sel.joy1)
			data_in = joy1_byte;
		else if (sel.joy2)
			data_in = joy2_byte;
		else if (sel.status)
			data_in = apu_status;   // Only readable APU register
		else if (sel.apu)
			data_in = open_bus;     // Write-only APU registers
		else if (sel.open)
			data_in = open_bus;     // 4018h..40FFh
		else if (sel.ppu)
			data_in = ppu_rdata;
		else
			data_in = mem_rdata;    // RAM and cartridge space
	end

	// Bus capacitance holds the previous byte
	always_ff @(posedge clk) begin
		open_bus <= data_in;
	end

endmodule

/* rtl/nes_bus_top.sv */
//----------------------------------------
// NES CPU bus core
//----------------------------------------
module nes_bus_top import nes_bus_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       pal,
	input  cpu_req_t   cpu_req,
	input  dmc_req_t   dmc,
	input  byte_t      ppu_rdata,
	input  byte_t      apu_status,
	input  byte_t      mem_rdata,
	input  logic [3:0] joypad_data,
	input  logic       mic,
	output logic       cpu_ce,
	output logic       ppu_ce,
	output logic       ppu_io,
	output bus_cycle_t bus,
	output byte_t      data_in,     // Read byte for the CPU and DMA
	output logic       pause_cpu,   // CPU must hold while high
	output logic       dmc_ack,
	output logic       joypad_strobe,
	output logic [1:0] joypad_clock
);

	logic       odd_cycle;
	logic       sprite_trigger;
	logic       dma_active;
	bus_cycle_t dma_cycle;
	chip_sel_t  sel;

	nes_clock_gen u_clock_gen (
		.clk       (clk),
		.reset     (reset),
		.pal       (pal),
		.cpu_ce    (cpu_ce),
		.ppu_ce    (ppu_ce),
		.ppu_io    (ppu_io),
		.odd_cycle (odd_cycle)
	);

	oam_dmc_dma u_dma (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.sprite_trigger (sprite_trigger),
		.cpu_req        (cpu_req),
		.dmc            (dmc),
		.rdata          (data_in),       // Sprite bytes come back through the mux
		.dma_cycle      (dma_cycle),
		.dma_active     (dma_active),
		.pause_cpu      (pause_cpu),
		.dmc_ack        (dmc_ack)
	);

	bus_decode u_decode (
		.cpu_req        (cpu_req),
		.dma_cycle      (dma_cycle),
		.dma_active     (dma_active),
		.bus            (bus),
		.sel            (sel),
		.sprite_trigger (sprite_trigger),
		.joypad_strobe  (joypad_strobe),
		.joypad_clock   (joypad_clock)
	);

	read_data_mux u_read_mux (
		.clk         (clk),
		.reset       (reset),
		.sel         (sel),
		.ppu_rdata   (ppu_rdata),
		.apu_status  (apu_status),
		.mem_rdata   (mem_rdata),
		.joypad_data (joypad_data),
		.mic         (mic),
		.data_in     (data_in)
	);

endmodule

/* verif/bus_monitor.sv */
//----------------------------------------
// NES bus checker
//----------------------------------------
module bus_monitor import nes_bus_pkg::*; (
	input logic       clk,
	input logic       reset,
	input logic       pal,
	input logic       cpu_ce,
	input logic       ppu_ce,
	input logic       ppu_io,
	input bus_cycle_t bus,
	input byte_t      data_in,
	input logic       pause_cpu,
	input logic       dmc_ack,
	input logic       joypad_strobe,
	input logic [1:0] joypad_clock,
	input cpu_req_t   cpu_req,     // Stimulus as driven by the testbench
	input byte_t      mem_rdata,
	input logic       check_en,    // Current cycle carries a file line
	input byte_t      exp_data,
	input logic       dma_phase,
	input byte_t      dma_page,
	input int         dmc_exp,     // DMC fetches expected in this DMA
	input addr_t      dmc_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	int    data_errors = 0;
	int    decode_errors = 0;
	int    dma_errors = 0;
	int    clock_errors = 0;
	int    ppu_count = 0;   // ppu_ce seen in the running CPU cycle
	int    cycle_idx = 0;   // CPU cycles since reset with the parity in bit 0
	int    spr_idx = 0;     // Sprite writes completed
	int    ack_count = 0;
	logic  pending = 1'b0;  // Read seen, write still owed
	byte_t read_val;

	// One finished cycle of a sprite or DMC transfer
	task automatic check_dma();
		if (!pause_cpu) begin                 // Transfer over
			if (spr_idx != 256 || pending) begin
				$display("Fail at %0t: sprite DMA ended after %0d writes", $time, spr_idx);
				dma_errors++;
			end
			if (ack_count != dmc_exp) begin
				$display("Fail at %0t: %0d DMC acks, expected %0d", $time, ack_count, dmc_exp);
				dma_errors++;
			end
		end else if (dmc_ack) begin
			ack_count++;
			if (!bus.read || bus.addr != dmc_addr) begin
				$display("Fail at %0t: DMC cycle at %h, read %b", $time, bus.addr, bus.read);
				dma_errors++;
			end
		end else if (bus.read && bus.addr[15:8] == dma_page) begin
			if (pending || bus.addr[7:0] != spr_idx[7:0] || data_in != mem_rdata) begin
				$display("Fail at %0t: sprite read %h, expected index %h", $time,
					bus.addr, spr_idx[7:0]);
				dma_errors++;
			end
			read_val = mem_rdata;                 // Byte the write must carry
			pending = 1'b1;
		end else if (bus.write) begin
			if (bus.addr != oam_data_reg || !pending || bus.wdata != read_val) begin
				$display("Fail at %0t: sprite write %h data %h, expected 2004 data %h",
					$time, bus.addr, bus.wdata, read_val);
				dma_errors++;
			end
			spr_idx++;
			pending = 1'b0;
		end
	endtask

	always @(posedge clk) begin : sample
		int         ticks;
		int         want_ticks;
		logic       long_cycle;
		logic       exp_strobe;
		logic [1:0] exp_clock;
		if (reset) begin
			ppu_count = 0;
			cycle_idx = 0;
		end else begin
			ticks = ppu_count + (ppu_ce ? 1 : 0);
			ppu_count = cpu_ce ? 0 : ticks;
			// PAL stretches every fifth cycle by one PPU tick
			long_cycle = pal && (cycle_idx % 5 == 4);
			// Register access lands on the second tick or on the third of a long cycle
			if (ppu_ce && ppu_io != (ticks == (long_cycle ? 3 : 2))) begin
				$display("Fail at %0t: ppu_io %b on PPU tick %0d of CPU cycle %0d",
					$time, ppu_io, ticks, cycle_idx);
				clock_errors++;
			end
			if (cpu_ce) begin
				want_ticks = long_cycle ? 4 : 3;
				if (ticks != want_ticks) begin
					$display("Fail at %0t: %0d PPU ticks in CPU cycle %0d, expected %0d",
						$time, ticks, cycle_idx, want_ticks);
					clock_errors++;
				end
				if (dmc_ack && (cycle_idx[0] || !dma_phase)) begin
					$display("Fail at %0t: dmc_ack in cycle %0d", $time, cycle_idx);
					dma_errors++;
				end
				// Joypad lines follow the CPU request only
				exp_strobe = !dma_phase && !cpu_req.rnw && cpu_req.addr == joy1_reg
					&& cpu_req.wdata[0];
				exp_clock[0] = !dma_phase && cpu_req.rnw && cpu_req.addr == joy1_reg;
				exp_clock[1] = !dma_phase && cpu_req.rnw && cpu_req.addr == joy2_reg;
				if (joypad_strobe != exp_strobe || joypad_clock != exp_clock) begin
					$display("Fail at %0t: joypad strobe %b clock %b, expected %b %b",
						$time, joypad_strobe, joypad_clock, exp_strobe, exp_clock);
					decode_errors++;
				end
				if (dma_phase)
					check_dma();
				else begin
					spr_idx = 0;
					ack_count = 0;
					pending = 1'b0;
					if (check_en && data_in != exp_data) begin
						$display("Fail at %0t: data_in %h at %h, expected %h",
							$time, data_in, cpu_req.addr, exp_data);
						data_errors++;
					end
				end
				cycle_idx++;
			end
		end
	end

endmodule

/* verif/tb_nes_bus.sv */
//----------------------------------------
// NES bus core testbench
//----------------------------------------
module tb_nes_bus import nes_bus_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int max_tests = 64;
	localparam int dmc_start = 100; // DMA cycle that raises the DMC request

	logic       clk;
	logic       reset;
	logic       pal;
	cpu_req_t   cpu_req;
	dmc_req_t   dmc;
	byte_t      ppu_rdata;
	byte_t      apu_status;
	byte_t      mem_rdata;
	logic [3:0] joypad_data;
	logic       mic;
	logic       cpu_ce;
	logic       ppu_ce;
	logic       ppu_io;
	bus_cycle_t bus;
	byte_t      data_in;
	logic       pause_cpu;
	logic       dmc_ack;
	logic       joypad_strobe;
	logic [1:0] joypad_clock;

	// Expectations handed to the monitor
	logic  check_en;
	byte_t exp_data;
	logic  dma_phase;
	byte_t dma_page;
	int    dmc_exp;

	int          n_tests = 0;
	int          n_dma = 0;
	int          limit_ns;
	int          total;
	logic        tests_loaded = 1'b0;
	logic [31:0] lcg_state = 32'h9f77_0c54;

	logic [3:0] t_mode [max_tests];
	addr_t      t_addr [max_tests];
	logic       t_rnw [max_tests];
	byte_t      t_wdata [max_tests];
	byte_t      t_ppu [max_tests];
	byte_t      t_apu [max_tests];
	byte_t      t_mem [max_tests];
	logic [3:0] t_joy [max_tests];
	logic       t_mic [max_tests];
	byte_t      t_exp [max_tests];

	nes_bus_top dut (.*);

	bus_monitor monitor (.*, .dmc_addr(dmc.addr));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic byte_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];  // High bits have the longest period
	endfunction

	// Edge that closes a CPU cycle
	task automatic wait_cycle_end();
		@(posedge clk);
		while (!cpu_ce)
			@(posedge clk);
	endtask

	task automatic load_tests();
		int          fd;
		int          code;
		string       text;
		logic [31:0] f [10];
		fd = $fopen("verif/nes_bus_tests.txt", "r");
		if (fd == 0)
			$display("Cannot open verif/nes_bus_tests.txt");
		else begin
			while (!$feof(fd)) begin
				code = $fgets(text, fd);
				if (code > 1 && text.getc(0) != "/") begin
					code = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
						f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
					if (code == 10 && n_tests < max_tests) begin
						t_mode[n_tests]  = f[0][3:0];
						t_addr[n_tests]  = f[1][15:0];
						t_rnw[n_tests]   = f[2][0];
						t_wdata[n_tests] = f[3][7:0];
						t_ppu[n_tests]   = f[4][7:0];
						t_apu[n_tests]   = f[5][7:0];
						t_mem[n_tests]   = f[6][7:0];
						t_joy[n_tests]   = f[7][3:0];
						t_mic[n_tests]   = f[8][0];
						t_exp[n_tests]   = f[9][7:0];
						if (f[0][3:0] != 4'd0)
							n_dma++;
						n_tests++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_test(input int i);
		cpu_req     <= '{addr: t_addr[i], rnw: t_rnw[i], wdata: t_wdata[i]};
		ppu_rdata   <= t_ppu[i];
		apu_status  <= t_apu[i];
		mem_rdata   <= t_mem[i];
		joypad_data <= t_joy[i];
		mic         <= t_mic[i];
		exp_data    <= t_exp[i];
		check_en    <= 1'b1;
		dma_phase   <= 1'b0;
	endtask

	// Halted CPU keeps reading while the DMA runs
	task automatic run_dma(input logic [3:0] mode, input byte_t page);
		int   n;
		logic busy;
		n = 0;
		busy = 1'b1;
		cpu_req   <= '{addr: 16'h8000, rnw: 1'b1, wdata: 8'h00};
		check_en  <= 1'b0;
		dma_phase <= 1'b1;
		dma_page  <= page;
		dmc_exp   <= (mode == 4'd2) ? 1 : 0;
		while (busy) begin
			mem_rdata <= next_rand();
			ppu_rdata <= next_rand();
			if (dmc_ack)
				dmc.trigger <= 1'b0;          // Request served
			else if (mode == 4'd2 && n == dmc_start)
				dmc.trigger <= 1'b1;
			n++;
			wait_cycle_end();
			busy = pause_cpu;
		end
	endtask

	initial begin
		watchdog_wait: begin
			wait (tests_loaded);
			#(limit_ns);
			$display("Timeout: run still going after %0d ns", limit_ns);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		pal = 1'b0;
		cpu_req = '{addr: 16'h8000, rnw: 1'b1, wdata: 8'h00};
		dmc = '{trigger: 1'b0, addr: 16'hc123};
		ppu_rdata = 8'h00;
		apu_status = 8'h00;
		mem_rdata = 8'h00;
		joypad_data = 4'h0;
		mic = 1'b0;
		check_en = 1'b0;
		exp_data = 8'h00;
		dma_phase = 1'b0;
		dma_page = 8'h00;
		dmc_exp = 0;
		load_tests();
		if (n_tests == 0)
			$display("No test lines were read");
		// Lines, sprite transfers and the PAL pass, in master clocks
		limit_ns = (40 + n_tests * 20 + n_dma * 600 * int'(cpu_div) + 40 * 16) * 8;
		tests_loaded = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		wait_cycle_end();
		for (int i = 0; i < n_tests; i++) begin
			drive_test(i);
			wait_cycle_end();
			if (t_mode[i] != 4'd0)
				run_dma(t_mode[i], t_wdata[i]);
		end
		// PAL cadence, standard is only taken in reset
		reset     <= 1'b1;
		pal       <= 1'b1;
		check_en  <= 1'b0;
		dma_phase <= 1'b0;
		cpu_req   <= '{addr: 16'h8000, rnw: 1'b1, wdata: 8'h00};
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		repeat (30) wait_cycle_end();
		total = monitor.data_errors + monitor.decode_errors + monitor.dma_errors
			+ monitor.clock_errors;
		$display("Errors: data %0d, decode %0d, dma %0d, clock %0d over %0d lines",
			monitor.data_errors, monitor.decode_errors, monitor.dma_errors,
			monitor.clock_errors, n_tests);
		if (total == 0 && n_tests > 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* nes_bus.f */
common/nes_bus_pkg.sv
rtl/nes_clock_gen.sv
dma/oam_dmc_dma.sv
rtl/bus_decode.sv
rtl/read_data_mux.sv
rtl/nes_bus_top.sv
verif/bus_monitor.sv
verif/tb_nes_bus.sv

/* run.sh */
#!/bin/sh
# Builds the NES bus testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f nes_bus.f --top-module tb_nes_bus -o tb_nes_bus &&
./obj_dir/tb_nes_bus | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" || { echo "FAIL"; exit 1; }

/* verif/nes_bus_tests.txt */
// mode(0 plain, 1 sprite DMA, 2 sprite DMA with DMC) addr rnw wdata
// ppu_rdata apu_status mem_rdata joypad mic expected_data_in
0 0000 0 5a 11 22 3c 0 0 3c
0 0123 1 00 11 22 a7 0 0 a7
0 2002 1 00 c5 22 a7 0 0 c5
0 3ff7 1 00 e1 22 a7 0 0 e1
0 4015 1 00 11 4f a7 0 0 4f
0 4016 1 00 11 22 a7 1 1 45
0 2000 1 00 f0 22 a7 0 0 f0
0 4017 1 00 11 22 a7 e 0 f9
0 4000 1 00 11 22 a7 0 0 f9
0 4020 1 00 11 22 a7 0 0 f9
0 40ff 1 00 11 22 a7 0 0 f9
0 4100 1 00 11 22 6b 0 0 6b
0 4016 0 01 11 22 6b 0 0 60
0 4016 0 00 11 22 6b 0 0 60
1 4014 0 02 11 22 6b 0 0 60
0 0200 1 00 11 22 9e 0 0 9e
2 4014 0 03 11 22 9e 0 0 9e
0 4015 1 00 11 80 9e 0 0 80
0 4016 1 00 11 22 9e 1 0 81
0 8000 1 00 11 22 d3 0 0 d3
